//--- Bender.yml
package:
  name: cache_bank

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/cache_pkg.sv
      - hdl/req_stage.sv
      - hdl/tag_array.sv
      - hdl/data_array.sv
      - hdl/miss_ctrl.sv
      - hdl/resp_stage.sv
      - hdl/cache_bank_top.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - sim/mem_model.sv
      - sim/tb_cache_bank.sv

//--- cache_bank_top.f
+incdir+hdl
hdl/cache_pkg.sv
hdl/req_stage.sv
hdl/tag_array.sv
hdl/data_array.sv
hdl/miss_ctrl.sv
hdl/resp_stage.sv
hdl/cache_bank_top.sv
sim/mem_model.sv
sim/tb_cache_bank.sv

//--- sim/tb_cache_bank.sv
`timescale 1ns/1ns

`include "cache_defs.svh"

module tb_cache_bank
  import cache_pkg::*;
();

  localparam logic [`CB_ID_W-1:0] BANK_ID = 3'd5;
  localparam int LINE_IDX_W = `CB_TAG_W + `CB_IDX_W;
  localparam int LINES      = 1 << LINE_IDX_W;
  localparam int N_DIR      = 13;
  localparam int N_RAND     = 300;
  localparam int TIMEOUT    = 40 * (N_DIR + N_RAND) + 100;

  // Expected response of one accepted request
  typedef struct packed {
    paddr_u                paddr;
    logic [`CB_LINE_W-1:0] data;
    logic                  hit_exp;
    logic                  cold;
    logic [31:0]           acc_cyc;
  } exp_t;

  logic                  clk;
  logic                  rst_n;
  logic                  valid_in;
  cache_req_t            req;
  logic                  cache_stall;
  logic                  fill_valid;
  logic [`CB_LINE_W-1:0] fill_data;
  logic                  wb_valid;
  bus_req_t              wb;
  logic                  fill_req;
  bus_req_t              fill;
  logic                  ex_valid;
  logic [`CB_LINE_W-1:0] ex_data;
  paddr_u                ex_paddr;
  logic                  ex_wake;

  logic [`CB_LINE_W-1:0] shadow [LINES];
  logic                  touched [LINES];
  logic                  written [LINES];
  logic [LINE_IDX_W-1:0] last_line;
  exp_t                  exp_q [$];
  exp_t                  head = '0;
  logic                  q_empty = 1'b1;
  logic                  head_fill_seen = 1'b0;
  int unsigned           cyc;
  int                    n_acc;
  int                    n_resp;
  int                    n_wb;
  int                    n_fill;
  int                    errors;

  cache_bank_top #(
    .BANK_ID (BANK_ID)
  ) cache_bank_top_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .valid_in    (valid_in),
    .req         (req),
    .cache_stall (cache_stall),
    .fill_valid  (fill_valid),
    .fill_data   (fill_data),
    .wb_valid    (wb_valid),
    .wb          (wb),
    .fill_req    (fill_req),
    .fill        (fill),
    .ex_valid    (ex_valid),
    .ex_data     (ex_data),
    .ex_paddr    (ex_paddr),
    .ex_wake     (ex_wake)
  );

  mem_model mem_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .fill_req   (fill_req),
    .fill       (fill),
    .wb_valid   (wb_valid),
    .wb         (wb),
    .fill_valid (fill_valid),
    .fill_data  (fill_data)
  );

  always #10 clk = ~clk;

  function automatic logic [LINE_IDX_W-1:0] line_of(input paddr_u a);
    return {a.f.tag, a.f.idx};
  endfunction

  function automatic logic [`CB_LINE_W-1:0] rand_line();
    return {$urandom, $urandom, $urandom, $urandom};
  endfunction

  function automatic cache_req_t build_req(input logic [`CB_TAG_W-1:0] tag,
                                           input logic [`CB_IDX_W-1:0] idx,
                                           input logic [`CB_OFF_W-1:0] off,
                                           input logic wr,
                                           input logic [`CB_LINE_W-1:0] wdata,
                                           input logic [MASK_W-1:0] mask);
    cache_req_t r;
    r.paddr.f.tag = tag;
    r.paddr.f.idx = idx;
    r.paddr.f.off = off;
    r.write       = wr;
    r.wdata       = wdata;
    r.mask        = mask;
    return r;
  endfunction

  // Masked bytes of a write replace the old line, a read keeps it
  function automatic logic [`CB_LINE_W-1:0] merge_bytes(input logic [`CB_LINE_W-1:0] old,
                                                        input cache_req_t r);
    logic [`CB_LINE_W-1:0] res;
    res = old;
    for (int b = 0; b < MASK_W; b++) begin
      if (r.write && r.mask[b]) begin
        res[b*8 +: 8] = r.wdata[b*8 +: 8];
      end
    end
    return res;
  endfunction

  task automatic record_accept(input cache_req_t r);
    exp_t                  e;
    logic [LINE_IDX_W-1:0] l;
    l         = line_of(r.paddr);
    e.paddr   = r.paddr;
    e.data    = merge_bytes(shadow[l], r);
    e.hit_exp = (n_acc > 0) && (l == last_line);
    e.cold    = !touched[l];
    e.acc_cyc = cyc;
    if (r.write) begin
      shadow[l]  = e.data;
      written[l] = 1'b1;
    end
    touched[l] = 1'b1;
    last_line  = l;
    exp_q.push_back(e);
    n_acc++;
  endtask

  // Hold the strobe until an edge with the bank not stalled
  task automatic send_req(input cache_req_t r);
    valid_in <= 1'b1;
    req      <= r;
    @(posedge clk);
    while (cache_stall) begin
      @(posedge clk);
    end
    valid_in <= 1'b0;
  endtask

  task automatic run_directed();
    send_req(build_req(8'h10, 3'd2, 4'h4, 1'b0, '0, '0));
    send_req(build_req(8'h10, 3'd2, 4'h8, 1'b0, '0, '0));
    send_req(build_req(8'h10, 3'd2, 4'h0, 1'b1, rand_line(), 16'h00f0));
    send_req(build_req(8'h10, 3'd2, 4'h0, 1'b0, '0, '0));
    // Fill the rest of set 2 with dirty lines, the last one evicts
    for (int t = 1; t <= 4; t++) begin
      send_req(build_req(8'(16 + t), 3'd2, 4'h0, 1'b1, rand_line(), 16'h8001));
    end
    for (int t = 0; t <= 4; t++) begin
      send_req(build_req(8'(16 + t), 3'd2, 4'hc, 1'b0, '0, '0));
    end
  endtask

  // Bookkeeping at each edge, from the values before the edge
  always @(posedge clk) begin
    cyc++;
    if (rst_n) begin
      if (valid_in && !cache_stall) begin
        record_accept(req);
      end
      if (fill_req) begin
        head_fill_seen = 1'b1;
        n_fill++;
      end
      if (wb_valid) begin
        n_wb++;
      end
      if (ex_valid) begin
        n_resp++;
        if (exp_q.size() > 0) begin
          void'(exp_q.pop_front());
          head_fill_seen = 1'b0;
        end
      end
      q_empty = (exp_q.size() == 0);
      head    = q_empty ? '0 : exp_q[0];
    end
  end

  a_reset_idle: assert property (@(negedge clk)
    n_acc == 0 |-> {ex_valid, wb_valid, fill_req, cache_stall} == 4'b0000)
    else begin
      errors++;
      $display("Fail at %0t: {ex_valid,wb_valid,fill_req,cache_stall} is %b, expected 0000",
               $time, {ex_valid, wb_valid, fill_req, cache_stall});
    end

  a_pulse: assert property (@(negedge clk) ex_valid |=> !ex_valid)
    else begin
      errors++;
      $display("Fail at %0t: ex_valid is 1, expected 0 after a one-cycle pulse", $time);
    end

  a_no_extra: assert property (@(negedge clk) ex_valid |-> !q_empty)
    else begin
      errors++;
      $display("Response at %0t with no request outstanding", $time);
    end

  a_paddr: assert property (@(negedge clk)
    ex_valid && !q_empty |-> ex_paddr == head.paddr)
    else begin
      errors++;
      $display("Fail at %0t: ex_paddr is %h, expected %h", $time, ex_paddr, head.paddr);
    end

  a_data: assert property (@(negedge clk)
    ex_valid && !q_empty |-> ex_data == head.data)
    else begin
      errors++;
      $display("Fail at %0t: ex_data is %h, expected %h", $time, ex_data, head.data);
    end

  a_wake: assert property (@(negedge clk)
    ex_valid && !q_empty && (head.hit_exp || head.cold) |-> ex_wake == head.hit_exp)
    else begin
      errors++;
      $display("Fail at %0t: ex_wake is %b, expected %b", $time, ex_wake, head.hit_exp);
    end

  // Sure hit, two edges from acceptance to the response
  a_hit_latency: assert property (@(negedge clk)
    ex_valid && !q_empty && head.hit_exp |-> cyc == head.acc_cyc + 2)
    else begin
      errors++;
      $display("Fail at %0t: ex_valid cycle is %0d, expected %0d",
               $time, cyc, head.acc_cyc + 2);
    end

  a_cold_fill: assert property (@(negedge clk)
    ex_valid && !q_empty && head.cold |-> head_fill_seen)
    else begin
      errors++;
      $display("Cold miss at %0t answered without a fill request", $time);
    end

  a_fill_addr: assert property (@(negedge clk)
    fill_req |-> fill.paddr.raw == {line_of(head.paddr), 4'h0})
    else begin
      errors++;
      $display("Fail at %0t: fill.paddr is %h, expected %h",
               $time, fill.paddr.raw, {line_of(head.paddr), 4'h0});
    end

  a_fill_id: assert property (@(negedge clk) fill_req |-> fill.id == BANK_ID)
    else begin
      errors++;
      $display("Fail at %0t: fill.id is %0d, expected %0d", $time, fill.id, BANK_ID);
    end

  // Stall may drop only in the cycle right before the response
  a_miss_stall: assert property (@(negedge clk)
    !q_empty && !ex_valid && !cache_stall |=> ex_valid)
    else begin
      errors++;
      $display("cache_stall dropped before %0t while a request was still in progress",
               $time);
    end

  a_wb_line: assert property (@(negedge clk)
    wb_valid |-> written[line_of(wb.paddr)] && wb.paddr.f.off == '0)
    else begin
      errors++;
      $display("Writeback at %0t of line %h that was never written or is not aligned",
               $time, wb.paddr.raw);
    end

  a_wb_data: assert property (@(negedge clk)
    wb_valid |-> wb.data == shadow[line_of(wb.paddr)])
    else begin
      errors++;
      $display("Fail at %0t: wb.data is %h, expected %h",
               $time, wb.data, shadow[line_of(wb.paddr)]);
    end

  a_wb_id: assert property (@(negedge clk) wb_valid |-> wb.id == BANK_ID)
    else begin
      errors++;
      $display("Fail at %0t: wb.id is %0d, expected %0d", $time, wb.id, BANK_ID);
    end

  initial begin
    while (cyc < TIMEOUT) begin
      @(negedge clk);
    end
    $display("Timeout after %0d cycles with %0d of %0d responses and %0d errors",
             cyc, n_resp, n_acc, errors);
    $display("Test failed");
    $finish;
  end

  initial begin
    cache_req_t           r;
    logic [`CB_TAG_W-1:0] t;
    logic [`CB_IDX_W-1:0] ix;
    void'($urandom(2274));
    clk      = 1'b0;
    rst_n    = 1'b0;
    valid_in = 1'b0;
    req      = '0;
    t        = '0;
    ix       = '0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    for (int l = 0; l < LINES; l++) begin
      shadow[l]  = mem_i.mem[l];
      touched[l] = 1'b0;
      written[l] = 1'b0;
    end
    // Quiet window for the idle check after reset
    repeat (4) @(posedge clk);
    run_directed();
    // Six tags per set over four ways keeps evictions coming
    for (int n = 0; n < N_RAND; n++) begin
      if ($urandom_range(3, 0) == 0) begin
        @(posedge clk);
      end
      if ($urandom_range(3, 0) != 0) begin
        t  = 8'($urandom_range(5, 0));
        ix = 3'($urandom_range(7, 0));
      end
      r = build_req(t, ix, 4'($urandom), 1'($urandom), rand_line(), 16'($urandom));
      send_req(r);
    end
    @(negedge clk);
    while (n_resp < n_acc) begin
      @(negedge clk);
    end
    repeat (8) @(negedge clk);
    $display("Requests %0d, responses %0d, writebacks %0d, fills %0d, errors %0d",
             n_acc, n_resp, n_wb, n_fill, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- sim/mem_model.sv
`timescale 1ns/1ns

`include "cache_defs.svh"

module mem_model
  import cache_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  fill_req,
  input  bus_req_t              fill,
  input  logic                  wb_valid,
  input  bus_req_t              wb,
  output logic                  fill_valid,
  output logic [`CB_LINE_W-1:0] fill_data
);

  localparam int LINE_IDX_W = `CB_TAG_W + `CB_IDX_W;
  localparam int LINES      = 1 << LINE_IDX_W;

  // Backing store, one entry per line address
  logic [`CB_LINE_W-1:0] mem [LINES];

  logic                  pending;
  int unsigned           wait_cnt;
  logic [LINE_IDX_W-1:0] fill_line;

  // Every address bit feeds the initial byte value
  function automatic logic [7:0] init_byte(input logic [`CB_ADDR_W-1:0] a);
    return (a[7:0] ^ {1'b0, a[14:8]}) + 8'h3c;
  endfunction

  initial begin
    for (int l = 0; l < LINES; l++) begin
      for (int b = 0; b < MASK_W; b++) begin
        mem[l][b*8 +: 8] = init_byte({l[LINE_IDX_W-1:0], b[`CB_OFF_W-1:0]});
      end
    end
  end

  // Fill returns 2 to 6 cycles after the request pulse
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fill_valid <= 1'b0;
      fill_data  <= '0;
      pending    <= 1'b0;
      wait_cnt   <= 0;
    end else begin
      fill_valid <= 1'b0;
      if (fill_req) begin
        pending   <= 1'b1;
        fill_line <= fill.paddr.raw[`CB_ADDR_W-1:`CB_OFF_W];
        wait_cnt  <= $urandom_range(6, 2) - 1;
      end else if (pending) begin
        if (wait_cnt == 0) begin
          fill_valid <= 1'b1;
          fill_data  <= mem[fill_line];
          pending    <= 1'b0;
        end else begin
          wait_cnt <= wait_cnt - 1;
        end
      end
      if (wb_valid) begin
        mem[wb.paddr.raw[`CB_ADDR_W-1:`CB_OFF_W]] <= wb.data;
      end
    end
  end

endmodule

//--- hdl/cache_bank_top.sv
`timescale 1ns/1ns

`include "cache_defs.svh"

module cache_bank_top
  import cache_pkg::*;
#(
  parameter logic [`CB_ID_W-1:0] BANK_ID = '0
) (
  input  logic                  clk,
  input  logic                  rst_n,

  // Request strobe and back-pressure
  input  logic                  valid_in,
  input  cache_req_t            req,
  output logic                  cache_stall,

  // Fill return from the bus
  input  logic                  fill_valid,
  input  logic [`CB_LINE_W-1:0] fill_data,

  // Bus channels
  output logic                  wb_valid,
  output bus_req_t              wb,
  output logic                  fill_req,
  output bus_req_t              fill,

  // Response to the output aligner
  output logic                  ex_valid,
  output logic [`CB_LINE_W-1:0] ex_data,
  output paddr_u                ex_paddr,
  output logic                  ex_wake
);

  logic                  cur_valid;
  cache_req_t            cur_req;
  lookup_t               lookup;
  logic                  done;
  logic                  hit_first;
  logic                  fill_install;
  logic [WAY_W-1:0]      install_way;
  logic [`CB_LINE_W-1:0] victim_line;
  logic [`CB_LINE_W-1:0] merged_line;

  req_stage req_stage_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .valid_in  (valid_in),
    .req       (req),
    .stall     (cache_stall),
    .cur_valid (cur_valid),
    .cur_req   (cur_req),
    .done      (done)
  );

  tag_array tag_array_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .cur_valid    (cur_valid),
    .cur_req      (cur_req),
    .lookup       (lookup),
    .fill_install (fill_install),
    .install_way  (install_way),
    .done         (done)
  );

  data_array data_array_i (
    .clk          (clk),
    .cur_req      (cur_req),
    .lookup       (lookup),
    .done         (done),
    .fill_install (fill_install),
    .install_way  (install_way),
    .fill_data    (fill_data),
    .rd_line      (),
    .victim_line  (victim_line),
    .merged_line  (merged_line)
  );

  // Busy doubles as the bank stall
  miss_ctrl #(
    .BANK_ID (BANK_ID)
  ) miss_ctrl_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .cur_valid    (cur_valid),
    .cur_req      (cur_req),
    .lookup       (lookup),
    .victim_line  (victim_line),
    .fill_valid   (fill_valid),
    .busy         (cache_stall),
    .done         (done),
    .hit_first    (hit_first),
    .fill_install (fill_install),
    .install_way  (install_way),
    .wb_valid     (wb_valid),
    .wb           (wb),
    .fill_req     (fill_req),
    .fill         (fill)
  );

  resp_stage resp_stage_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .done        (done),
    .hit_first   (hit_first),
    .cur_req     (cur_req),
    .merged_line (merged_line),
    .ex_valid    (ex_valid),
    .ex_data     (ex_data),
    .ex_paddr    (ex_paddr),
    .ex_wake     (ex_wake)
  );

endmodule

//--- hdl/resp_stage.sv
`timescale 1ns/1ns

`include "cache_defs.svh"

module resp_stage
  import cache_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  done,
  input  logic                  hit_first,
  input  cache_req_t            cur_req,
  input  logic [`CB_LINE_W-1:0] merged_line,

  // To the output aligner
  output logic                  ex_valid,
  output logic [`CB_LINE_W-1:0] ex_data,
  output paddr_u                ex_paddr,
  output logic                  ex_wake
);

  // One pulse per done, wake only for a first-lookup hit
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_valid <= 1'b0;
      ex_wake  <= 1'b0;
    end else begin
      ex_valid <= done;
      if (done) begin
        ex_wake <= hit_first;
      end
    end
  end

  // Line after the write merge, so a write returns its new contents
  always_ff @(posedge clk) begin
    if (done) begin
      ex_data  <= merged_line;
      ex_paddr <= cur_req.paddr;
    end
  end

endmodule

//--- hdl/miss_ctrl.sv
`timescale 1ns/1ns

`include "cache_defs.svh"

module miss_ctrl
  import cache_pkg::*;
#(
  parameter logic [`CB_ID_W-1:0] BANK_ID = '0
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  cur_valid,
  input  cache_req_t            cur_req,
  input  lookup_t               lookup,
  input  logic [`CB_LINE_W-1:0] victim_line,
  input  logic                  fill_valid,

  output logic                  busy,
  output logic                  done,
  output logic                  hit_first,
  output logic                  fill_install,
  output logic [WAY_W-1:0]      install_way,

  // Writeback channel, dirty victims only
  output logic                  wb_valid,
  output bus_req_t              wb,

  // Fill request channel
  output logic                  fill_req,
  output bus_req_t              fill
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_WB,
    S_REQ,
    S_WAIT,
    S_REPLAY
  } state_t;

  state_t               state;
  logic [WAY_W-1:0]     vic_way_q;
  logic [`CB_TAG_W-1:0] vic_tag_q;

  function automatic paddr_u line_addr(input logic [`CB_TAG_W-1:0] tag,
                                       input logic [`CB_IDX_W-1:0] idx);
    paddr_u a;
    a.f.tag = tag;
    a.f.idx = idx;
    a.f.off = '0;
    return a;
  endfunction

  // Stall for any lookup that is not completing this cycle
  assign busy = (state != S_IDLE) | (cur_valid & ~done);

  assign fill_install = (state == S_WAIT) & fill_valid;
  assign install_way  = vic_way_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= S_IDLE;
      done      <= 1'b0;
      hit_first <= 1'b0;
      wb_valid  <= 1'b0;
      fill_req  <= 1'b0;
      vic_way_q <= '0;
    end else begin
      done     <= 1'b0;
      wb_valid <= 1'b0;
      fill_req <= 1'b0;
      case (state)
        S_IDLE: begin
          if (cur_valid && !done) begin
            if (lookup.hit) begin
              done      <= 1'b1;
              hit_first <= 1'b1;
            end else begin
              vic_way_q <= lookup.victim_way;
              state     <= lookup.victim_dirty ? S_WB : S_REQ;
            end
          end
        end
        S_WB: begin
          wb_valid <= 1'b1;
          state    <= S_REQ;
        end
        S_REQ: begin
          fill_req <= 1'b1;
          state    <= S_WAIT;
        end
        S_WAIT: begin
          if (fill_valid) begin
            state <= S_REPLAY;
          end
        end
        S_REPLAY: begin
          // Line is now resident, so the replay hits
          if (lookup.hit) begin
            done      <= 1'b1;
            hit_first <= 1'b0;
            state     <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // Bus words follow the state one cycle later, with the pulse
  always_ff @(posedge clk) begin
    if (state == S_IDLE) begin
      vic_tag_q <= lookup.victim_tag;
    end
    if (state == S_WB) begin
      wb.paddr <= line_addr(vic_tag_q, cur_req.paddr.f.idx);
      wb.id    <= BANK_ID;
      wb.data  <= victim_line;
    end
    if (state == S_REQ) begin
      fill.paddr <= line_addr(cur_req.paddr.f.tag, cur_req.paddr.f.idx);
      fill.id    <= BANK_ID;
      fill.data  <= '0;
    end
  end

endmodule

//--- hdl/data_array.sv
`timescale 1ns/1ns

`include "cache_defs.svh"

module data_array
  import cache_pkg::*;
(
  input  logic                  clk,
  input  cache_req_t            cur_req,
  input  lookup_t               lookup,
  input  logic                  done,

  // Fill return written into the victim way
  input  logic                  fill_install,
  input  logic [WAY_W-1:0]      install_way,
  input  logic [`CB_LINE_W-1:0] fill_data,

  output logic [`CB_LINE_W-1:0] rd_line,
  output logic [`CB_LINE_W-1:0] victim_line,
  output logic [`CB_LINE_W-1:0] merged_line
);

  localparam int LINES = `CB_SETS * `CB_WAYS;

  // Line storage addressed by {set, way}
  logic [`CB_LINE_W-1:0] line_mem [LINES];

  logic [`CB_IDX_W+WAY_W-1:0] rd_addr;
  logic [`CB_IDX_W+WAY_W-1:0] vic_addr;
  logic [`CB_IDX_W+WAY_W-1:0] fill_addr;

  assign rd_addr   = {cur_req.paddr.f.idx, lookup.hit_way};
  assign vic_addr  = {cur_req.paddr.f.idx, lookup.victim_way};
  assign fill_addr = {cur_req.paddr.f.idx, install_way};

  assign rd_line     = line_mem[rd_addr];
  assign victim_line = line_mem[vic_addr];

  // Byte merge of the write data, a read passes the line through
  always_comb begin
    merged_line = rd_line;
    for (int b = 0; b < MASK_W; b++) begin
      if (cur_req.write && cur_req.mask[b]) begin
        merged_line[b*8 +: 8] = cur_req.wdata[b*8 +: 8];
      end
    end
  end

  // Install and write-hit never fall on the same edge
  always_ff @(posedge clk) begin
    if (fill_install) begin
      line_mem[fill_addr] <= fill_data;
    end else if (done && cur_req.write) begin
      line_mem[rd_addr] <= merged_line;
    end
  end

endmodule

//--- hdl/tag_array.sv
`timescale 1ns/1ns

`include "cache_defs.svh"

module tag_array
  import cache_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n,
  input  logic             cur_valid,
  input  cache_req_t       cur_req,
  output lookup_t          lookup,

  // Install of a returned fill into the victim way
  input  logic             fill_install,
  input  logic [WAY_W-1:0] install_way,

  input  logic             done
);

  logic [`CB_TAG_W-1:0]              tag_mem [`CB_SETS][`CB_WAYS];
  logic [`CB_SETS-1:0][`CB_WAYS-1:0] valid_q;
  logic [`CB_SETS-1:0][`CB_WAYS-1:0] dirty_q;
  logic [`CB_SETS-1:0][2:0]          plru_q;

  logic [`CB_IDX_W-1:0] idx;
  logic [`CB_TAG_W-1:0] tag;
  logic [`CB_WAYS-1:0]  set_valid;
  logic [2:0]           set_plru;
  logic [WAY_W-1:0]     plru_way;

  // Tree bits point away from the most recent use
  function automatic logic [2:0] plru_touch(input logic [2:0] cur, input logic [WAY_W-1:0] way);
    logic [2:0] nxt;
    nxt    = cur;
    nxt[0] = ~way[1];
    if (way[1]) begin
      nxt[2] = ~way[0];
    end else begin
      nxt[1] = ~way[0];
    end
    return nxt;
  endfunction

  assign idx       = cur_req.paddr.f.idx;
  assign tag       = cur_req.paddr.f.tag;
  assign set_valid = valid_q[idx];
  assign set_plru  = plru_q[idx];

  // Root picks the pair, the leaf bit picks the way in it
  assign plru_way = set_plru[0] ? {1'b1, set_plru[2]} : {1'b0, set_plru[1]};

  always_comb begin
    lookup = '0;
    for (int w = 0; w < `CB_WAYS; w++) begin
      if (set_valid[w] && tag_mem[idx][w] == tag) begin
        lookup.hit     = cur_valid;
        lookup.hit_way = WAY_W'(w);
      end
    end
    // Lowest invalid way wins over the tree
    lookup.victim_way = plru_way;
    for (int w = `CB_WAYS - 1; w >= 0; w--) begin
      if (!set_valid[w]) begin
        lookup.victim_way = WAY_W'(w);
      end
    end
    lookup.victim_tag   = tag_mem[idx][lookup.victim_way];
    lookup.victim_dirty = set_valid[lookup.victim_way] & dirty_q[idx][lookup.victim_way];
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
      dirty_q <= '0;
      plru_q  <= '0;
    end else begin
      if (fill_install) begin
        valid_q[idx][install_way] <= 1'b1;
        dirty_q[idx][install_way] <= 1'b0;
      end
      if (done && cur_valid) begin
        plru_q[idx] <= plru_touch(set_plru, lookup.hit_way);
        if (cur_req.write) begin
          dirty_q[idx][lookup.hit_way] <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fill_install) begin
      tag_mem[idx][install_way] <= tag;
    end
  end

endmodule

//--- hdl/req_stage.sv
`timescale 1ns/1ns

module req_stage
  import cache_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,

  // From the address queue side
  input  logic       valid_in,
  input  cache_req_t req,
  input  logic       stall,

  // Held request for the lookup and the miss sequencer
  output logic       cur_valid,
  output cache_req_t cur_req,

  input  logic       done
);

  logic accept;

  // Only taken while the bank is not stalled
  assign accept = valid_in & ~stall;

  // A new request on the done edge keeps the stage full,
  // so back-to-back hits stream without a bubble cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cur_valid <= 1'b0;
    end else if (accept) begin
      cur_valid <= 1'b1;
    end else if (done) begin
      cur_valid <= 1'b0;
    end
  end

  // Held unchanged through the whole miss sequence
  always_ff @(posedge clk) begin
    if (accept) begin
      cur_req <= req;
    end
  end

endmodule

//--- hdl/cache_pkg.sv
`include "cache_defs.svh"

package cache_pkg;

  localparam int WAY_W  = $clog2(`CB_WAYS);
  localparam int MASK_W = `CB_LINE_W / 8;

  // Address fields, tag in the upper bits
  typedef struct packed {
    logic [`CB_TAG_W-1:0] tag;
    logic [`CB_IDX_W-1:0] idx;
    logic [`CB_OFF_W-1:0] off;
  } paddr_fields_t;

  // Same address seen as a raw word or as its fields
  typedef union packed {
    logic [`CB_ADDR_W-1:0] raw;
    paddr_fields_t         f;
  } paddr_u;

  typedef struct packed {
    paddr_u                paddr;
    logic                  write;
    logic [`CB_LINE_W-1:0] wdata;
    logic [MASK_W-1:0]     mask;
  } cache_req_t;

  // Result of the tag compare on the indexed set
  typedef struct packed {
    logic                 hit;
    logic [WAY_W-1:0]     hit_way;
    logic [WAY_W-1:0]     victim_way;
    logic                 victim_dirty;
    logic [`CB_TAG_W-1:0] victim_tag;
  } lookup_t;

  // Word on a bus channel, data is don't care on the fill channel
  typedef struct packed {
    paddr_u                paddr;
    logic [`CB_ID_W-1:0]   id;
    logic [`CB_LINE_W-1:0] data;
  } bus_req_t;

endpackage

//--- hdl/cache_defs.svh
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// Physical address split into tag, set index and byte offset
`define CB_ADDR_W 15
`define CB_TAG_W  8
`define CB_IDX_W  3
`define CB_OFF_W  4

// Bank organization
`define CB_WAYS   4
`define CB_SETS   8

// One line is 16 bytes
`define CB_LINE_W 128

// Return id carried on the writeback and fill channels
`define CB_ID_W   3

`endif
